// File: hw/cpu_pkg.sv
package cpu_pkg;

  localparam int WORD_WIDTH = 8;

  typedef logic [WORD_WIDTH-1:0] word_t;

  typedef enum logic [2:0] {
    RESET_STAGE,
    FETCH_OPERATION,
    DECODE,
    FETCH_IMMEDIATE,
    EXECUTE,
    WRITE_REGISTER,
    WRITE_MEMORY
  } stage_t;

  // Shared by the operation fetch and the memory write
  typedef enum logic [1:0] {
    IDLE,
    BEGIN,
    FINISH
  } phase_t;

  typedef enum logic [3:0] {
    OF_IDLE,
    OF_BEGIN,
    WAIT_IMM,
    LOAD_IMM,
    WAIT_SRC_ADDR,
    LOAD_SRC_ADDR,
    WAIT_SRC,
    LOAD_SRC,
    WAIT_DST_ADDR,
    LOAD_DST_ADDR,
    WAIT_DST,
    LOAD_DST,
    OF_FINISH
  } opfetch_t;

  typedef enum logic [2:0] {
    MOV,
    ADD,
    JMP,
    NOP,
    HLT
  } opcode_t;

  typedef enum logic [2:0] {
    REG_A,
    ADDRESS_REG_A,
    ADDRESS_IMM,
    IMM,
    UNUSED
  } operand_t;

  typedef enum logic [1:0] {
    STAY,
    READ,
    WRITE
  } mem_cmd_t;

  // Instruction byte, seen either as fields or as a whole code
  typedef union packed {
    struct packed {
      logic [3:0] cls;
      logic [1:0] dst;
      logic [1:0] src;
    } fields;
    word_t raw;
  } instr_word_u;

  localparam word_t NOP_CODE = 8'hFE;
  localparam word_t HLT_CODE = 8'hFF;

  localparam logic [3:0] MOV_CLASS = 4'h0;
  localparam logic [3:0] ADD_CLASS = 4'h1;
  localparam logic [3:0] JMP_CLASS = 4'hC;

  localparam logic [1:0] MODE_REG_A         = 2'd0;
  localparam logic [1:0] MODE_ADDRESS_REG_A = 2'd1;
  localparam logic [1:0] MODE_ADDRESS_IMM   = 2'd2;
  localparam logic [1:0] MODE_IMM           = 2'd3;

  function automatic phase_t step_phase(phase_t p);
    case (p)
      IDLE:    return BEGIN;
      BEGIN:   return FINISH;
      default: return IDLE;
    endcase
  endfunction

endpackage

// File: hw/stage_control.sv
`timescale 1ns/1ns

module stage_control (
    input  logic              CLOCK
  , input  logic              RESET
  , input  logic              fetch_done
  , input  logic              operands_done
  , input  logic              write_done
  , input  cpu_pkg::operand_t dst_mode
  , output cpu_pkg::stage_t   stage
);
  import cpu_pkg::*;

  stage_t next_stage;

  always_comb begin
    case (stage)
      RESET_STAGE:     next_stage = FETCH_OPERATION;
      FETCH_OPERATION: next_stage = fetch_done ? DECODE : FETCH_OPERATION;
      DECODE:          next_stage = FETCH_IMMEDIATE;
      FETCH_IMMEDIATE: next_stage = operands_done ? EXECUTE : FETCH_IMMEDIATE;

      // Where the result goes decides the next stage
      EXECUTE: begin
        case (dst_mode)
          REG_A:                      next_stage = WRITE_REGISTER;
          ADDRESS_REG_A, ADDRESS_IMM: next_stage = WRITE_MEMORY;
          default:                    next_stage = FETCH_OPERATION;
        endcase
      end

      WRITE_REGISTER:  next_stage = FETCH_OPERATION;
      WRITE_MEMORY:    next_stage = write_done ? FETCH_OPERATION : WRITE_MEMORY;
      default:         next_stage = FETCH_OPERATION;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      stage <= RESET_STAGE;
    end else begin
      stage <= next_stage;
    end
  end

endmodule

// File: hw/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  logic                 CLOCK
  , input  logic                 RESET
  , input  cpu_pkg::stage_t      stage
  , input  cpu_pkg::instr_word_u instr
  , output cpu_pkg::opcode_t     opcode
  , output cpu_pkg::operand_t    src_mode
  , output cpu_pkg::operand_t    dst_mode
);
  import cpu_pkg::*;

  opcode_t  dec_opcode;
  operand_t dec_src;
  operand_t dec_dst;

  function automatic operand_t mode_of(logic [1:0] m);
    case (m)
      MODE_REG_A:         return REG_A;
      MODE_ADDRESS_REG_A: return ADDRESS_REG_A;
      MODE_ADDRESS_IMM:   return ADDRESS_IMM;
      MODE_IMM:           return IMM;
      default:            return UNUSED;
    endcase
  endfunction

  always_comb begin
    // Undefined codes fall through as HLT
    dec_opcode = HLT;
    dec_src    = UNUSED;
    dec_dst    = UNUSED;
    if (instr.raw == NOP_CODE) begin
      dec_opcode = NOP;
    end else if (instr.raw == HLT_CODE) begin
      dec_opcode = HLT;
    end else if (instr.fields.cls == MOV_CLASS || instr.fields.cls == ADD_CLASS) begin
      dec_opcode = (instr.fields.cls == MOV_CLASS) ? MOV : ADD;
      dec_src    = mode_of(instr.fields.src);
      // Immediate destination means no destination
      dec_dst    = (instr.fields.dst == MODE_IMM) ? UNUSED : mode_of(instr.fields.dst);
    end else if (instr.fields.cls == JMP_CLASS) begin
      dec_opcode = JMP;
      dec_src    = IMM;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      opcode   <= NOP;
      src_mode <= UNUSED;
      dst_mode <= UNUSED;
    end else if (stage == DECODE) begin
      opcode   <= dec_opcode;
      src_mode <= dec_src;
      dst_mode <= dec_dst;
    end
  end

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                 CLOCK
  , input  logic                 RESET
  , input  cpu_pkg::stage_t      stage
  , input  cpu_pkg::opcode_t     opcode
  , input  cpu_pkg::word_t       read_bus
  , input  cpu_pkg::word_t       imm
  , input  logic                 ip_advance
  , output cpu_pkg::instr_word_u instr
  , output cpu_pkg::word_t       ip
  , output logic                 fetch_done
);
  import cpu_pkg::*;

  phase_t phase;
  logic   fetching;
  logic   step_ip;

  assign fetching   = (stage == FETCH_OPERATION);
  assign fetch_done = fetching && (phase == FINISH);

  // The HLT byte keeps ip on itself so it is fetched again
  assign step_ip = fetch_done && (instr.raw != HLT_CODE);

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      phase <= IDLE;
    end else begin
      phase <= fetching ? step_phase(phase) : IDLE;
    end
  end

  // Memory answers during BEGIN
  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      instr.raw <= NOP_CODE;
    end else if (fetching && phase == BEGIN) begin
      instr.raw <= read_bus;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      ip <= '0;
    end else if (opcode != HLT) begin
      if (step_ip || ip_advance) begin
        ip <= ip + 8'd1;
      end else if (stage == EXECUTE && opcode == JMP) begin
        // Relative to the byte after the offset
        ip <= ip + imm;
      end
    end
  end

endmodule

// File: hw/operand_fetch.sv
`timescale 1ns/1ns

module operand_fetch (
    input  logic              CLOCK
  , input  logic              RESET
  , input  cpu_pkg::stage_t   stage
  , input  cpu_pkg::operand_t src_mode
  , input  cpu_pkg::operand_t dst_mode
  , input  cpu_pkg::word_t    read_bus
  , input  cpu_pkg::word_t    reg_a
  , input  cpu_pkg::word_t    ip
  , output cpu_pkg::word_t    imm
  , output cpu_pkg::word_t    mem_src
  , output cpu_pkg::word_t    mem_dst
  , output cpu_pkg::word_t    dst_addr
  , output cpu_pkg::word_t    op_addr
  , output logic              ip_advance
  , output logic              operands_done
);
  import cpu_pkg::*;

  opfetch_t state;
  opfetch_t next_state;
  word_t    src_addr;

  // Destination reads come last
  function automatic opfetch_t dst_step(operand_t dm);
    case (dm)
      ADDRESS_IMM:   return WAIT_DST_ADDR;
      ADDRESS_REG_A: return WAIT_DST;
      default:       return OF_FINISH;
    endcase
  endfunction

  always_comb begin
    next_state = OF_IDLE;
    if (stage == FETCH_IMMEDIATE) begin
      case (state)
        OF_IDLE: next_state = OF_BEGIN;
        OF_BEGIN: begin
          case (src_mode)
            IMM:           next_state = WAIT_IMM;
            ADDRESS_IMM:   next_state = WAIT_SRC_ADDR;
            ADDRESS_REG_A: next_state = WAIT_SRC;
            default:       next_state = dst_step(dst_mode);
          endcase
        end
        WAIT_IMM:      next_state = LOAD_IMM;
        LOAD_IMM:      next_state = dst_step(dst_mode);
        WAIT_SRC_ADDR: next_state = LOAD_SRC_ADDR;
        LOAD_SRC_ADDR: next_state = WAIT_SRC;
        WAIT_SRC:      next_state = LOAD_SRC;
        LOAD_SRC:      next_state = dst_step(dst_mode);
        WAIT_DST_ADDR: next_state = LOAD_DST_ADDR;
        LOAD_DST_ADDR: next_state = WAIT_DST;
        WAIT_DST:      next_state = LOAD_DST;
        LOAD_DST:      next_state = OF_FINISH;
        default:       next_state = OF_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      state <= OF_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge CLOCK) begin
    case (state)
      LOAD_IMM:      imm      <= read_bus;
      LOAD_SRC_ADDR: src_addr <= read_bus;
      LOAD_SRC:      mem_src  <= read_bus;
      LOAD_DST_ADDR: dst_addr <= read_bus;
      LOAD_DST:      mem_dst  <= read_bus;
      default: ;
    endcase
  end

  assign ip_advance    = (state == LOAD_IMM) || (state == LOAD_SRC_ADDR) ||
                         (state == LOAD_DST_ADDR);
  assign operands_done = (state == OF_FINISH);

  // Same address through WAIT and LOAD
  always_comb begin
    op_addr = '0;
    case (state)
      WAIT_IMM, LOAD_IMM, WAIT_SRC_ADDR, LOAD_SRC_ADDR,
      WAIT_DST_ADDR, LOAD_DST_ADDR: op_addr = ip;
      WAIT_SRC, LOAD_SRC: op_addr = (src_mode == ADDRESS_IMM) ? src_addr : reg_a;
      WAIT_DST, LOAD_DST: op_addr = (dst_mode == ADDRESS_IMM) ? dst_addr : reg_a;
      default:            op_addr = '0;
    endcase
  end

endmodule

// File: hw/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
    input  logic              CLOCK
  , input  logic              RESET
  , input  cpu_pkg::stage_t   stage
  , input  cpu_pkg::opcode_t  opcode
  , input  cpu_pkg::operand_t src_mode
  , input  cpu_pkg::operand_t dst_mode
  , input  cpu_pkg::word_t    imm
  , input  cpu_pkg::word_t    mem_src
  , input  cpu_pkg::word_t    mem_dst
  , output cpu_pkg::word_t    result
  , output cpu_pkg::word_t    reg_a
);
  import cpu_pkg::*;

  word_t src_val;
  word_t dst_val;

  always_comb begin
    case (src_mode)
      REG_A:                      src_val = reg_a;
      ADDRESS_REG_A, ADDRESS_IMM: src_val = mem_src;
      IMM:                        src_val = imm;
      default:                    src_val = '0;
    endcase
  end

  // Value the destination held before this instruction
  always_comb begin
    case (dst_mode)
      REG_A:                      dst_val = reg_a;
      ADDRESS_REG_A, ADDRESS_IMM: dst_val = mem_dst;
      default:                    dst_val = '0;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (stage == EXECUTE) begin
      case (opcode)
        ADD:     result <= dst_val + src_val;
        MOV:     result <= src_val;
        default: result <= dst_val;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      reg_a <= '0;
    end else if (stage == WRITE_REGISTER) begin
      reg_a <= result;
    end
  end

endmodule

// File: hw/memory_port.sv
`timescale 1ns/1ns

module memory_port (
    input  logic              CLOCK
  , input  logic              RESET
  , input  cpu_pkg::stage_t   stage
  , input  cpu_pkg::operand_t dst_mode
  , input  cpu_pkg::word_t    reg_a
  , input  cpu_pkg::word_t    dst_addr
  , input  cpu_pkg::word_t    result
  , input  cpu_pkg::word_t    ip
  , input  cpu_pkg::word_t    op_addr
  , output cpu_pkg::mem_cmd_t ctrl_bus
  , output cpu_pkg::word_t    addr_bus
  , output cpu_pkg::word_t    write_bus
  , output logic              write_done
);
  import cpu_pkg::*;

  phase_t phase;
  logic   writing;
  word_t  write_addr;

  assign writing    = (stage == WRITE_MEMORY);
  assign write_done = writing && (phase == FINISH);
  assign write_addr = (dst_mode == ADDRESS_IMM) ? dst_addr : reg_a;

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      phase     <= IDLE;
      write_bus <= '0;
    end else begin
      phase <= writing ? step_phase(phase) : IDLE;
      // Held steady over both WRITE cycles
      if (writing && phase == IDLE) begin
        write_bus <= result;
      end
    end
  end

  always_comb begin
    case (stage)
      FETCH_OPERATION: addr_bus = ip;
      FETCH_IMMEDIATE: addr_bus = op_addr;
      WRITE_MEMORY:    addr_bus = write_addr;
      default:         addr_bus = '0;
    endcase
  end

  always_comb begin
    case (stage)
      FETCH_OPERATION, FETCH_IMMEDIATE: ctrl_bus = READ;
      WRITE_MEMORY:    ctrl_bus = (phase == IDLE) ? STAY : WRITE;
      default:         ctrl_bus = STAY;
    endcase
  end

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
    input  logic              CLOCK
  , input  logic              RESET
  , input  cpu_pkg::word_t    read_bus
  , output cpu_pkg::mem_cmd_t ctrl_bus
  , output cpu_pkg::word_t    addr_bus
  , output cpu_pkg::word_t    write_bus
  , output cpu_pkg::word_t    OUT
);
  import cpu_pkg::*;

  stage_t      stage;
  logic        fetch_done;
  logic        operands_done;
  logic        write_done;

  instr_word_u instr;
  opcode_t     opcode;
  operand_t    src_mode;
  operand_t    dst_mode;

  word_t       ip;
  logic        ip_advance;

  word_t       imm;
  word_t       mem_src;
  word_t       mem_dst;
  word_t       dst_addr;
  word_t       op_addr;

  word_t       result;
  word_t       reg_a;

  stage_control stage_control0 (.*);

  instr_decoder instr_decoder0 (.*);

  fetch_unit fetch_unit0 (.*);

  operand_fetch operand_fetch0 (.*);

  execute_unit execute_unit0 (.*);

  memory_port memory_port0 (.*);

  assign OUT = reg_a;

endmodule

// File: test/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;
  import cpu_pkg::*;

  localparam int PROGRAMS = 20;
  localparam int PROG_LEN = 40;
  // 20 programs of about 45 instructions at up to 19 cycles, plus reset
  localparam int MAX_CYCLES = 20000;

  logic     CLOCK;
  logic     RESET;
  word_t    read_bus;
  mem_cmd_t ctrl_bus;
  word_t    addr_bus;
  word_t    write_bus;
  word_t    OUT;

  word_t    mem [256];
  word_t    ref_mem [256];
  word_t    model_mem [256];
  word_t    read_addr;
  mem_cmd_t prev_ctrl;

  word_t    trace [$];
  word_t    wr_addr [$];
  word_t    wr_data [$];
  word_t    model_a;

  int       seed = 14;
  int       errors = 0;
  int       cycles = 0;
  int       fetch_cnt = 0;
  int       read_bursts = 0;
  int       wr_cnt = 0;
  logic     halted = 1'b0;
  word_t    last_fetch;

  cpu_top dut (.*);

  initial begin
    CLOCK = 1'b0;
    forever #10 CLOCK = ~CLOCK;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] got);
    if (got !== expected) begin
      errors++;
      $display("ERROR %0t %s expected=%0h got=%0h", $time, name, expected, got);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%0t: %s", $time, msg);
  endtask

  function automatic word_t data_addr();
    return 8'hC0 | ({$random(seed)} % 64);
  endfunction

  // Code at 00..7F, random data everywhere else
  task automatic build_program();
    word_t pc;
    int    i;
    int    count;
    int    kind;
    int    src;
    int    dst;
    int    off;
    for (i = 0; i < 256; i++) begin
      ref_mem[i] = $random(seed);
    end
    pc = 8'h00;
    count = 0;
    while (count < PROG_LEN && pc < 8'h7A) begin
      kind = {$random(seed)} % 8;
      if (kind == 0) begin
        ref_mem[pc] = NOP_CODE;
        pc++;
      end else if (kind == 1) begin
        off = {$random(seed)} % 3;
        ref_mem[pc] = {JMP_CLASS, 4'h0};
        ref_mem[pc + 1] = off;
        pc += 2;
        for (i = 0; i < off; i++) begin
          ref_mem[pc] = NOP_CODE;
          pc++;
        end
      end else begin
        src = {$random(seed)} % 4;
        dst = {$random(seed)} % 3;
        if (src == 1 || dst == 1) begin
          // Point A into the data region first
          ref_mem[pc] = {MOV_CLASS, MODE_REG_A, MODE_IMM};
          ref_mem[pc + 1] = data_addr();
          pc += 2;
        end
        ref_mem[pc] = {(kind < 5) ? MOV_CLASS : ADD_CLASS, dst[1:0], src[1:0]};
        pc++;
        if (src >= 2) begin
          ref_mem[pc] = (src == 2) ? data_addr() : word_t'($random(seed));
          pc++;
        end
        if (dst == 2) begin
          ref_mem[pc] = data_addr();
          pc++;
        end
      end
      count++;
    end
    ref_mem[pc] = HLT_CODE;
  endtask

  // Instruction-level model of the ISA
  task automatic run_model();
    word_t pc;
    word_t op;
    word_t p;
    word_t src_v;
    word_t dst_v;
    word_t addr;
    word_t val;
    int    steps;
    model_mem = ref_mem;
    trace.delete();
    wr_addr.delete();
    wr_data.delete();
    pc = 8'h00;
    model_a = 8'h00;
    for (steps = 0; steps < 200; steps++) begin
      trace.push_back(pc);
      op = model_mem[pc];
      if (op == NOP_CODE) begin
        pc = pc + 1;
      end else if (op[7:4] == JMP_CLASS) begin
        // Offset counts from the byte after it
        pc = pc + 2 + model_mem[pc + 1];
      end else if (op[7:4] == MOV_CLASS || op[7:4] == ADD_CLASS) begin
        p = pc + 1;
        case (op[1:0])
          2'd0: src_v = model_a;
          2'd1: src_v = model_mem[model_a];
          2'd2: begin
            src_v = model_mem[model_mem[p]];
            p++;
          end
          default: begin
            src_v = model_mem[p];
            p++;
          end
        endcase
        addr = model_a;
        if (op[3:2] == 2'd2) begin
          addr = model_mem[p];
          p++;
        end
        dst_v = (op[3:2] == 2'd0) ? model_a : model_mem[addr];
        val = (op[7:4] == ADD_CLASS) ? word_t'(dst_v + src_v) : src_v;
        if (op[3:2] == 2'd0) begin
          model_a = val;
        end else if (op[3:2] != 2'd3) begin
          model_mem[addr] = val;
          wr_addr.push_back(addr);
          wr_data.push_back(val);
        end
        pc = p;
      end else begin
        // HLT and undefined codes stop the program
        break;
      end
    end
  endtask

  task automatic see_fetch(input word_t addr);
    word_t expected;
    expected = (fetch_cnt < trace.size()) ? trace[fetch_cnt] : trace[$];
    check_value("addr_bus", expected, addr);
    if (fetch_cnt > 0 && addr == last_fetch && !halted) begin
      halted = 1'b1;
      if (addr != trace[$]) begin
        note_failure($sformatf("CPU halted at %02h but the program halts at %02h",
                               addr, trace[$]));
      end
    end
    last_fetch = addr;
    fetch_cnt++;
  endtask

  task automatic see_write(input word_t addr, input word_t data);
    if (halted) begin
      note_failure("memory write after the CPU halted");
    end else if (wr_cnt >= wr_addr.size()) begin
      note_failure("more memory writes than the program makes");
    end else begin
      check_value("addr_bus", wr_addr[wr_cnt], addr);
      check_value("write_bus", wr_data[wr_cnt], data);
    end
    wr_cnt++;
  endtask

  // Memory model and bus monitor
  always @(negedge CLOCK) begin
    read_bus = mem[read_addr];
    if (RESET) begin
      fetch_cnt   = 0;
      read_bursts = 0;
      wr_cnt      = 0;
      halted      = 1'b0;
      prev_ctrl   = STAY;
    end else begin
      if (ctrl_bus == READ && prev_ctrl != READ) begin
        // Operation and operand reads take turns
        if (read_bursts % 2 == 0) begin
          see_fetch(addr_bus);
        end
        read_bursts++;
      end
      if (ctrl_bus == WRITE && prev_ctrl != WRITE) begin
        see_write(addr_bus, write_bus);
      end
      if (ctrl_bus == WRITE) begin
        mem[addr_bus] = write_bus;
      end
      if (ctrl_bus == READ) begin
        read_addr = addr_bus;
      end
      prev_ctrl = ctrl_bus;
    end
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge CLOCK);
      cycles++;
    end
    $display("Timeout after %0d cycles, the CPU did not reach its halt", cycles);
    $display("%0d errors", errors + dut.chk.failures);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int i;
    RESET     = 1'b1;
    read_bus  = '0;
    read_addr = '0;
    prev_ctrl = STAY;
    for (int prog = 0; prog < PROGRAMS; prog++) begin
      build_program();
      run_model();
      @(negedge CLOCK);
      RESET <= 1'b1;
      @(posedge CLOCK);
      mem = ref_mem;
      repeat (16) @(negedge CLOCK);
      check_value("OUT", 0, OUT);
      check_value("ctrl_bus", STAY, ctrl_bus);
      check_value("addr_bus", 0, addr_bus);
      check_value("write_bus", 0, write_bus);
      RESET <= 1'b0;
      @(negedge CLOCK);
      check_value("OUT", 0, OUT);
      wait (halted);
      // Watch the HLT loop for a while
      repeat (60) @(negedge CLOCK);
      check_value("OUT", model_a, OUT);
      check_value("write count", wr_addr.size(), wr_cnt);
      for (i = 8'hC0; i < 256; i++) begin
        check_value($sformatf("mem[%02h]", i), model_mem[i], mem[i]);
      end
    end
    errors += dut.chk.failures;
    $display("%0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: test/cpu_chk.sv
`timescale 1ns/1ns

module cpu_chk (
    input  logic              CLOCK
  , input  logic              RESET
  , input  cpu_pkg::mem_cmd_t ctrl_bus
  , input  cpu_pkg::word_t    addr_bus
  , input  cpu_pkg::word_t    write_bus
);
  import cpu_pkg::*;

  int failures = 0;

  idle_after_reset: assert property (@(posedge CLOCK) RESET |=> ctrl_bus == STAY)
    else begin
      $error("ctrl_bus is not STAY after reset");
      failures++;
    end

  // A write burst is exactly two cycles
  write_two_cycles: assert property (@(posedge CLOCK) disable iff (RESET)
      (ctrl_bus == WRITE && $past(ctrl_bus) != WRITE)
      |=> ctrl_bus == WRITE ##1 ctrl_bus != WRITE)
    else begin
      $error("WRITE on ctrl_bus does not last two cycles");
      failures++;
    end

  write_steady: assert property (@(posedge CLOCK) disable iff (RESET)
      (ctrl_bus == WRITE && $past(ctrl_bus) == WRITE)
      |-> $stable(addr_bus) && $stable(write_bus))
    else begin
      $error("addr_bus or write_bus moved during a write");
      failures++;
    end

endmodule

bind cpu_top cpu_chk chk (.*);

// File: project.f
hw/cpu_pkg.sv
hw/stage_control.sv
hw/instr_decoder.sv
hw/fetch_unit.sv
hw/operand_fetch.sv
hw/execute_unit.sv
hw/memory_port.sv
hw/cpu_top.sv
test/cpu_tb.sv
test/cpu_chk.sv

// File: Bender.yml
package:
  name: accumulator_cpu

sources:
  - hw/cpu_pkg.sv
  - hw/stage_control.sv
  - hw/instr_decoder.sv
  - hw/fetch_unit.sv
  - hw/operand_fetch.sv
  - hw/execute_unit.sv
  - hw/memory_port.sv
  - hw/cpu_top.sv
  - target: test
    files:
      - test/cpu_tb.sv
      - test/cpu_chk.sv
